// ==== rtl/dec_param_pkg.sv ====
// decoder numeric parameters
`default_nettype none

package dec_param_pkg;

  // --------------------
  // defaults, overridden from the top level
  localparam int llr_w_def = 5;   // systematic llr width
  localparam int tag_w_def = 8;   // user tag width
  localparam int n_max_def = 64;  // max duobits per block

  localparam int err_w = 16;      // erasure counter width

  // ceiling log2, never below one bit
  function automatic int addr_w_of(input int n);
    int w;
    w = 1;
    while ((1 << w) < n) begin
      w++;
    end
    return w;
  endfunction

endpackage

`default_nettype wire

// ==== rtl/dec_types_pkg.sv ====
// decoder payload and descriptor types
`default_nettype none

package dec_types_pkg;

  import dec_param_pkg::*;

  // address width at the default block size
  localparam int addr_w_def = addr_w_of(n_max_def);

  typedef logic signed [llr_w_def-1:0] llr_t;

  // one received duobit, input buffer payload
  typedef struct packed {
    llr_t a;  // first systematic bit
    llr_t b;  // second systematic bit
  } llr_pair_t;

  typedef logic [1:0] dbit_t;  // one decided duobit

  // per-bank block descriptor
  typedef struct packed {
    logic [addr_w_def:0]  n;    // block length, up to n_max inclusive
    logic [tag_w_def-1:0] tag;
    logic [err_w-1:0]     err;  // erased duobits
  } blk_desc_t;

endpackage

`default_nettype wire

// ==== rtl/dec_buf_if.sv ====
// ping-pong buffer write and read interfaces
`default_nettype none

// --------------------
// write side, one bank filled per block
interface buf_wr_if #(
  parameter type dat_t  = logic,
  parameter type desc_t = logic,
  parameter int  addr_w = dec_param_pkg::addr_w_of(dec_param_pkg::n_max_def)
);
  logic              write;     // strobe
  logic [addr_w-1:0] addr;
  dat_t              dat;
  logic              done;      // closes the write bank
  desc_t             desc;      // valid with done
  logic              full_any;  // no free bank left

  modport producer (output write, addr, dat, done, desc, input full_any);
  modport buffer   (input write, addr, dat, done, desc, output full_any);
endinterface

// --------------------
// read side, one full bank drained per block
interface buf_rd_if #(
  parameter type dat_t  = logic,
  parameter type desc_t = logic,
  parameter int  addr_w = dec_param_pkg::addr_w_of(dec_param_pkg::n_max_def)
);
  logic              ready;         // read bank holds a block
  logic [addr_w-1:0] addr;
  dat_t              dat;           // one cycle after addr
  desc_t             desc;          // stable while ready
  logic              release_bank;  // frees the read bank

  modport consumer (input ready, dat, desc, output addr, release_bank);
  modport buffer   (output ready, dat, desc, input addr, release_bank);
endinterface

`default_nettype wire

// ==== rtl/dec_source.sv ====
// input block framer
`default_nettype none

module dec_source #(
  parameter int n_max = dec_param_pkg::n_max_def
) (
  input  logic                                      iclk,
  input  logic                                      rst,
  input  logic                                      src_sop,
  input  logic                                      src_eop,
  input  logic                                      src_val,
  input  dec_types_pkg::llr_t                       src_llr_a,
  input  dec_types_pkg::llr_t                       src_llr_b,
  input  logic [dec_param_pkg::addr_w_of(n_max):0]  src_n,
  input  logic [dec_param_pkg::tag_w_def-1:0]       src_tag,
  output logic                                      busy,
  output logic                                      rdy,
  buf_wr_if.producer                                wr
);
  import dec_param_pkg::*;
  import dec_types_pkg::*;

  localparam int addr_w = addr_w_of(n_max);

  logic                 open;     // sop seen, eop pending
  logic [addr_w-1:0]    waddr;    // next entry
  logic [addr_w:0]      n_q;
  logic [tag_w_def-1:0] tag_q;
  blk_desc_t            desc_c;
  llr_pair_t            pair_c;

  // --------------------
  // handshake levels
  assign rdy  = !wr.full_any && !open;
  assign busy = !rdy;

  // sop beat bypasses the captured fields
  always_comb begin
    desc_c.n   = src_sop ? src_n : n_q;
    desc_c.tag = src_sop ? src_tag : tag_q;
    desc_c.err = '0;  // filled in by the engine
    pair_c.a   = src_llr_a;
    pair_c.b   = src_llr_b;
  end

  assign wr.write = src_val;
  assign wr.addr  = src_sop ? '0 : waddr;  // restart on every sop
  assign wr.dat   = pair_c;
  assign wr.done  = src_val && src_eop;    // close bank on last beat
  assign wr.desc  = desc_c;

  // --------------------
  // framing state
  always_ff @(posedge iclk) begin
    if (rst) begin
      open  <= 1'b0;
      waddr <= '0;
    end else if (src_val) begin
      waddr <= wr.addr + 1'b1;
      if (src_eop) begin
        open <= 1'b0;
      end else if (src_sop) begin
        open <= 1'b1;
      end
    end
  end

  // block fields, held for the rest of the block
  always_ff @(posedge iclk) begin
    if (src_sop && src_val) begin
      n_q   <= src_n;
      tag_q <= src_tag;
    end
  end

  // upstream must wait for rdy before opening a block
  a_sop_not_busy : assert property (@(posedge iclk) disable iff (rst)
    (src_sop && src_val) |-> !busy);

endmodule

`default_nettype wire

// ==== rtl/dec_pingpong_buf.sv ====
// two-bank block buffer
`default_nettype none

module dec_pingpong_buf #(
  parameter type dat_t  = logic,
  parameter type desc_t = logic,
  parameter int  n_max  = dec_param_pkg::n_max_def
) (
  input  logic      iclk,
  input  logic      rst,
  buf_wr_if.buffer  wr,
  buf_rd_if.buffer  rd
);
  import dec_param_pkg::*;

  localparam int addr_w = addr_w_of(n_max);

  dat_t       mem    [0:1][0:n_max-1];
  desc_t      desc_q [0:1];   // descriptor per bank
  logic [1:0] full;           // bank holds a closed block
  logic       wbank;          // bank being filled
  logic       rbank;          // bank being drained
  logic [addr_w-1:0] raddr;

  // --------------------
  // status
  assign wr.full_any = full[wbank];  // write bank not free yet
  assign rd.ready    = full[rbank];
  assign rd.desc     = desc_q[rbank];
  assign raddr       = rd.addr;

  // bank pointers and full flags
  always_ff @(posedge iclk) begin
    if (rst) begin
      full  <= 2'b00;
      wbank <= 1'b0;
      rbank <= 1'b0;
    end else begin
      // done and release never hit the same bank
      if (wr.done) begin
        full[wbank] <= 1'b1;
        wbank       <= ~wbank;
      end
      if (rd.release_bank) begin
        full[rbank] <= 1'b0;
        rbank       <= ~rbank;
      end
    end
  end

  // --------------------
  // storage
  always_ff @(posedge iclk) begin
    if (wr.write) begin
      mem[wbank][wr.addr] <= wr.dat;
    end
    if (wr.done) begin
      desc_q[wbank] <= wr.desc;
    end
    rd.dat <= mem[rbank][raddr];  // registered read
  end

  // producer must respect full_any across the interface
  a_no_write_full : assert property (@(posedge iclk) disable iff (rst)
    (wr.write || wr.done) |-> !wr.full_any);

  // consumer frees only a bank it was offered
  a_no_release_empty : assert property (@(posedge iclk) disable iff (rst)
    rd.release_bank |-> rd.ready);

endmodule

`default_nettype wire

// ==== rtl/dec_hard_engine.sv ====
// hard decision engine
`default_nettype none

module dec_hard_engine #(
  parameter int n_max = dec_param_pkg::n_max_def
) (
  input  logic       iclk,
  input  logic       rst,
  buf_rd_if.consumer rd,
  buf_wr_if.producer wr
);
  import dec_param_pkg::*;
  import dec_types_pkg::*;

  localparam int addr_w = addr_w_of(n_max);

  logic              active;     // block in progress
  logic              issuing;    // read addresses going out
  logic              start;
  logic [addr_w-1:0] raddr;
  logic [addr_w:0]   n_last;
  logic              last_addr;
  logic              wr_val;     // read data valid this cycle
  logic [addr_w-1:0] wr_addr;
  logic              last_d;
  logic              done_q;
  logic [err_w-1:0]  err_cnt;
  llr_pair_t         pair;
  dbit_t             dec;
  logic              erased;
  blk_desc_t         desc_in;
  blk_desc_t         desc_out;

  // --------------------
  // read side
  assign desc_in   = rd.desc;
  assign n_last    = desc_in.n - 1'b1;
  assign last_addr = (raddr == n_last[addr_w-1:0]);
  assign start     = !active && rd.ready && !wr.full_any;
  assign rd.addr   = raddr;

  always_ff @(posedge iclk) begin
    if (rst) begin
      active  <= 1'b0;
      issuing <= 1'b0;
      raddr   <= '0;
      wr_val  <= 1'b0;
      last_d  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      if (start) begin
        active  <= 1'b1;
        issuing <= 1'b1;
        raddr   <= '0;
      end else if (issuing) begin
        if (last_addr) begin
          issuing <= 1'b0;
        end else begin
          raddr <= raddr + 1'b1;
        end
      end
      wr_val <= issuing;                // data back one cycle later
      last_d <= issuing && last_addr;
      done_q <= last_d;                 // two cycles after last addr
      if (done_q) begin
        active <= 1'b0;
      end
    end
  end

  // --------------------
  // decision and erasure count
  assign pair   = rd.dat;
  assign dec[0] = pair.a[llr_w_def-1];  // negative llr -> 1
  assign dec[1] = pair.b[llr_w_def-1];
  assign erased = (pair.a == '0) || (pair.b == '0);

  always_ff @(posedge iclk) begin
    wr_addr <= raddr;
    if (start) begin
      err_cnt <= '0;
    end else if (wr_val && erased) begin
      err_cnt <= err_cnt + 1'b1;
    end
  end

  always_comb begin
    desc_out.n   = desc_in.n;    // same block
    desc_out.tag = desc_in.tag;
    desc_out.err = err_cnt;
  end

  assign wr.write        = wr_val;
  assign wr.addr         = wr_addr;
  assign wr.dat          = dec;
  assign wr.done         = done_q;
  assign wr.desc         = desc_out;
  assign rd.release_bank = done_q;   // input bank freed with output close

endmodule

`default_nettype wire

// ==== rtl/dec_sink.sv ====
// output block streamer
`default_nettype none

module dec_sink #(
  parameter int n_max = dec_param_pkg::n_max_def
) (
  input  logic                                iclk,
  input  logic                                rst,
  input  logic                                snk_req,
  output logic                                snk_full,
  output logic                                snk_sop,
  output logic                                snk_eop,
  output logic                                snk_val,
  output dec_types_pkg::dbit_t                snk_dat,
  output logic [dec_param_pkg::tag_w_def-1:0] snk_tag,
  output logic [dec_param_pkg::err_w-1:0]     snk_err,
  buf_rd_if.consumer                          rd
);
  import dec_param_pkg::*;
  import dec_types_pkg::*;

  localparam int addr_w = addr_w_of(n_max);

  logic [addr_w-1:0] raddr;
  logic [addr_w:0]   n_last;
  logic              last_addr;
  logic              issue;   // one read this cycle
  logic              hold;    // last read out, waiting for release
  logic              rel_q;
  blk_desc_t         desc;

  // --------------------
  // read requests
  assign desc      = rd.desc;
  assign n_last    = desc.n - 1'b1;
  assign last_addr = (raddr == n_last[addr_w-1:0]);
  assign issue     = snk_req && rd.ready && !hold;  // req low holds address
  assign rd.addr   = raddr;

  always_ff @(posedge iclk) begin
    if (rst) begin
      raddr   <= '0;
      hold    <= 1'b0;
      rel_q   <= 1'b0;
      snk_val <= 1'b0;
      snk_sop <= 1'b0;
      snk_eop <= 1'b0;
    end else begin
      if (issue) begin
        raddr <= last_addr ? '0 : raddr + 1'b1;
      end
      if (issue && last_addr) begin
        hold <= 1'b1;
      end else if (rel_q) begin
        hold <= 1'b0;
      end
      // framing lags the address by one, like the data
      snk_val <= issue;
      snk_sop <= issue && (raddr == '0);
      snk_eop <= issue && last_addr;
      rel_q   <= snk_val && snk_eop;  // cycle after eop beat
    end
  end

  // --------------------
  // outputs
  assign snk_full        = rd.ready;
  assign snk_dat         = rd.dat;
  assign snk_tag         = desc.tag;
  assign snk_err         = desc.err;
  assign rd.release_bank = rel_q;

  // every beat comes from a bank that is still held
  a_val_in_block : assert property (@(posedge iclk) disable iff (rst)
    snk_val |-> rd.ready);

endmodule

`default_nettype wire

// ==== rtl/dec_top.sv ====
// duobinary decoder data path top
`default_nettype none

module dec_top #(
  parameter int llr_w = dec_param_pkg::llr_w_def,
  parameter int tag_w = dec_param_pkg::tag_w_def,
  parameter int n_max = dec_param_pkg::n_max_def
) (
  input  logic                                     iclk,
  input  logic                                     rst,
  input  logic                                     src_sop,
  input  logic                                     src_eop,
  input  logic                                     src_val,
  input  logic signed [llr_w-1:0]                  src_llr_a,
  input  logic signed [llr_w-1:0]                  src_llr_b,
  input  logic [dec_param_pkg::addr_w_of(n_max):0] src_n,
  input  logic [tag_w-1:0]                         src_tag,
  output logic                                     busy,
  output logic                                     rdy,
  input  logic                                     snk_req,
  output logic                                     snk_full,
  output logic                                     snk_sop,
  output logic                                     snk_eop,
  output logic                                     snk_val,
  output logic [1:0]                               snk_dat,
  output logic [tag_w-1:0]                         snk_tag,
  output logic [dec_param_pkg::err_w-1:0]          snk_err
);
  import dec_param_pkg::*;
  import dec_types_pkg::*;

  localparam int addr_w = addr_w_of(n_max);

  // --------------------
  // buffer links
  buf_wr_if #(.dat_t(llr_pair_t), .desc_t(blk_desc_t), .addr_w(addr_w)) ib_wr ();
  buf_rd_if #(.dat_t(llr_pair_t), .desc_t(blk_desc_t), .addr_w(addr_w)) ib_rd ();
  buf_wr_if #(.dat_t(dbit_t),     .desc_t(blk_desc_t), .addr_w(addr_w)) ob_wr ();
  buf_rd_if #(.dat_t(dbit_t),     .desc_t(blk_desc_t), .addr_w(addr_w)) ob_rd ();

  dec_source #(.n_max(n_max)) i_source (
    .iclk      (iclk),
    .rst       (rst),
    .src_sop   (src_sop),
    .src_eop   (src_eop),
    .src_val   (src_val),
    .src_llr_a (src_llr_a),
    .src_llr_b (src_llr_b),
    .src_n     (src_n),
    .src_tag   (src_tag),
    .busy      (busy),
    .rdy       (rdy),
    .wr        (ib_wr)
  );

  // llr pairs in
  dec_pingpong_buf #(.dat_t(llr_pair_t), .desc_t(blk_desc_t), .n_max(n_max)) ibuf (
    .iclk (iclk),
    .rst  (rst),
    .wr   (ib_wr),
    .rd   (ib_rd)
  );

  dec_hard_engine #(.n_max(n_max)) i_engine (
    .iclk (iclk),
    .rst  (rst),
    .rd   (ib_rd),
    .wr   (ob_wr)
  );

  // decided duobits out
  dec_pingpong_buf #(.dat_t(dbit_t), .desc_t(blk_desc_t), .n_max(n_max)) obuf (
    .iclk (iclk),
    .rst  (rst),
    .wr   (ob_wr),
    .rd   (ob_rd)
  );

  dec_sink #(.n_max(n_max)) i_sink (
    .iclk     (iclk),
    .rst      (rst),
    .snk_req  (snk_req),
    .snk_full (snk_full),
    .snk_sop  (snk_sop),
    .snk_eop  (snk_eop),
    .snk_val  (snk_val),
    .snk_dat  (snk_dat),
    .snk_tag  (snk_tag),
    .snk_err  (snk_err),
    .rd       (ob_rd)
  );

endmodule

`default_nettype wire

// ==== dv/tb_dec_top.sv ====
// decoder data path testbench
`default_nettype none

module tb_dec_top;
  timeunit 1ns;
  timeprecision 1ps;

  import dec_param_pkg::*;

  localparam int llr_w  = 5;
  localparam int tag_w  = 8;
  localparam int n_max  = 64;
  localparam int addr_w = addr_w_of(n_max);
  localparam int n_rows = 9;
  localparam int t_clk  = 40;  // ns

  localparam logic signed [llr_w-1:0] llr_zero = '0;

  // one block per row
  typedef struct packed {
    int         n;
    logic [7:0] tag;
    logic       duty;  // random req
    logic       hold;  // req withheld until a free row
  } row_t;

  // --------------------
  // stimulus table
  localparam row_t rows [n_rows] = '{
    '{8,  8'h11, 1'b0, 1'b0},
    '{5,  8'h22, 1'b1, 1'b0},
    '{16, 8'h33, 1'b0, 1'b1},  // four held rows fill both buffers
    '{3,  8'h44, 1'b1, 1'b1},
    '{12, 8'h55, 1'b0, 1'b1},
    '{7,  8'h66, 1'b1, 1'b1},
    '{1,  8'h77, 1'b1, 1'b0},  // single beat carries sop and eop
    '{64, 8'h88, 1'b1, 1'b0},  // full size block
    '{10, 8'h99, 1'b0, 1'b0}
  };

  logic                    iclk;
  logic                    rst;
  logic                    src_sop;
  logic                    src_eop;
  logic                    src_val;
  logic signed [llr_w-1:0] src_llr_a;
  logic signed [llr_w-1:0] src_llr_b;
  logic [addr_w:0]         src_n;
  logic [tag_w-1:0]        src_tag;
  logic                    busy;
  logic                    rdy;
  logic                    snk_req;
  logic                    snk_full;
  logic                    snk_sop;
  logic                    snk_eop;
  logic                    snk_val;
  logic [1:0]              snk_dat;
  logic [tag_w-1:0]        snk_tag;
  logic [err_w-1:0]        snk_err;

  integer           seed;
  logic [31:0]      req_rnd;
  logic             req_hold;     // req forced low
  logic             req_duty;     // req toggles at random
  logic             req_at_edge;  // req seen by the last rising edge
  int               errors;
  int               blocks_rcvd;
  int               beats_rcvd;
  int               beat_idx;     // position in current output block
  logic [1:0]       exp_dbit [$];
  int               exp_n    [$];
  logic [tag_w-1:0] exp_tag  [$];
  int               exp_err  [$];

  dec_top #(.llr_w(llr_w), .tag_w(tag_w), .n_max(n_max)) i_dut (.*);

  initial begin
    iclk = 1'b0;
    forever #(t_clk / 2) iclk = ~iclk;
  end

  function automatic int total_n();
    int s;
    s = 0;
    for (int i = 0; i < n_rows; i++) begin
      s += rows[i].n;
    end
    return s;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      errors++;
      $display("Error: %s = %h, expected %h at %0t ns", name, got, want, $time);
    end
  endtask

  // --------------------
  // source side
  task automatic send_block(input int r);
    logic signed [llr_w-1:0] a_buf [n_max];
    logic signed [llr_w-1:0] b_buf [n_max];
    logic [31:0]             rnd;
    int                      n;
    int                      err;
    n   = rows[r].n;
    err = 0;
    for (int i = 0; i < n; i++) begin
      rnd = $random(seed);
      a_buf[i] = rnd[llr_w-1:0];
      b_buf[i] = rnd[llr_w+7:8];
      if (i % 5 == 4) a_buf[i] = llr_zero;  // every fifth a erased
      exp_dbit.push_back({b_buf[i] < llr_zero, a_buf[i] < llr_zero});
      if (a_buf[i] == llr_zero || b_buf[i] == llr_zero) err++;
    end
    exp_n.push_back(n);
    exp_tag.push_back(rows[r].tag);
    exp_err.push_back(err);
    while (!rdy) @(negedge iclk);  // wait for a free input bank
    for (int i = 0; i < n; i++) begin
      src_val   = 1'b1;
      src_sop   = (i == 0);
      src_eop   = (i == n - 1);
      src_llr_a = a_buf[i];
      src_llr_b = b_buf[i];
      src_n     = n[addr_w:0];
      src_tag   = rows[r].tag;
      @(negedge iclk);
    end
    src_val = 1'b0;
    src_sop = 1'b0;
    src_eop = 1'b0;
  endtask

  // request pacing, random draw away from the llr draws
  always @(posedge iclk) req_rnd = $random(seed);

  always @(negedge iclk) begin
    if (rst || req_hold) snk_req = 1'b0;
    else if (req_duty) snk_req = req_rnd[3];
    else snk_req = 1'b1;
  end

  // --------------------
  // output monitor
  task automatic check_beat();
    logic [1:0] d;
    if (!req_at_edge) begin
      errors++;
      $display("output beat at %0t ns came without a request the cycle before", $time);
    end
    if (exp_n.size() == 0 || exp_dbit.size() == 0) begin
      errors++;
      $display("output beat at %0t ns with no block pending", $time);
      return;
    end
    d = exp_dbit.pop_front();
    check_value("snk_dat", snk_dat, d);
    check_value("snk_sop", snk_sop, beat_idx == 0);
    check_value("snk_eop", snk_eop, beat_idx == exp_n[0] - 1);
    check_value("snk_tag", snk_tag, exp_tag[0]);
    check_value("snk_err", snk_err, exp_err[0]);
    check_value("snk_full", snk_full, 1'b1);  // beat drawn from a held bank
    beats_rcvd++;
    if (beat_idx == exp_n[0] - 1) begin
      void'(exp_n.pop_front());
      void'(exp_tag.pop_front());
      void'(exp_err.pop_front());
      beat_idx = 0;
      blocks_rcvd++;
    end else begin
      beat_idx++;
    end
  endtask

  always @(posedge iclk) req_at_edge = snk_req;

  always @(negedge iclk) begin
    if (!rst && snk_val) check_beat();
  end

  initial begin : watchdog
    repeat (total_n() * 200 + 1000) @(posedge iclk);
    $display("timeout, %0d of %0d blocks received", blocks_rcvd, n_rows);
    $display("Errors found");
    $finish;
  end

  // --------------------
  // main sequence
  initial begin : stimulus
    int held;
    seed        = 32'h6209;
    errors      = 0;
    blocks_rcvd = 0;
    beats_rcvd  = 0;
    beat_idx    = 0;
    req_hold    = 1'b0;
    req_duty    = 1'b0;
    req_at_edge = 1'b0;
    rst         = 1'b1;
    src_sop     = 1'b0;
    src_eop     = 1'b0;
    src_val     = 1'b0;
    src_llr_a   = '0;
    src_llr_b   = '0;
    src_n       = '0;
    src_tag     = '0;
    snk_req     = 1'b0;
    repeat (3) @(negedge iclk);
    rst = 1'b0;
    @(negedge iclk);
    check_value("busy", busy, 1'b0);  // idle state after reset
    check_value("rdy", rdy, 1'b1);
    check_value("snk_val", snk_val, 1'b0);
    check_value("snk_full", snk_full, 1'b0);
    held = 0;
    for (int r = 0; r < n_rows; r++) begin
      if (rows[r].hold && held == 0) begin
        while (blocks_rcvd < r) @(negedge iclk);  // drain before stalling
      end
      req_hold = rows[r].hold;
      req_duty = rows[r].duty;
      send_block(r);
      held = rows[r].hold ? held + 1 : 0;
      if (held == 4 && !busy) begin
        errors++;
        $display("busy stayed low with both input banks full and output stalled");
      end
    end
    while (blocks_rcvd < n_rows) @(negedge iclk);
    repeat (5) @(negedge iclk);
    if (exp_dbit.size() != 0 || exp_n.size() != 0) begin
      errors++;
      $display("%0d expected duobits never came out", exp_dbit.size());
    end
    $display("%0d errors, %0d blocks and %0d beats checked", errors, blocks_rcvd, beats_rcvd);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/dec_param_pkg.sv
rtl/dec_types_pkg.sv
rtl/dec_buf_if.sv
rtl/dec_source.sv
rtl/dec_pingpong_buf.sv
rtl/dec_hard_engine.sv
rtl/dec_sink.sv
rtl/dec_top.sv
dv/tb_dec_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the decoder testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  --top-module tb_dec_top -f filelist.f \
  && ./obj_dir/Vtb_dec_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log && echo "simulation passed" && exit 0
echo "simulation failed" || true
exit 1
